//--- Bender.yml
package:
  name: usb_host_tx

sources:
  - src/usbPkg.sv
  - src/hostRegsPkg.sv
  - src/crcGenerator.sv
  - src/usbTxRegs.sv
  - src/packetSerializer.sv
  - src/bitStuffer.sv
  - src/lineDriver.sv
  - src/usbHostTx.sv
  - target: test
    files:
      - dv/usbHostTxTb.sv

//--- dv/usbHostTxTb.sv
module usbHostTxTb import usbPkg::*, hostRegsPkg::*;;

  localparam logic [31:0] Seed = 32'h65e373f9;
  localparam int MaxPacketCycles = 120;
  localparam int NumTests = 7;
  localparam int CycleLimit = 20 * MaxPacketCycles * NumTests;

  logic     clock = 1'b0;
  logic     reset_n;
  apbReq_t  apbReq;
  apbRsp_t  apbRsp;
  usbLine_t line;

  // Decoded packet from the line monitor
  logic [127:0] rxBits;
  logic [159:0] rawSyms;
  int           rxLen;
  int           rawLen;
  int           onesRun;
  int           se0Cnt;
  int           jCnt;
  logic         prevLevel;
  logic         inPacket = 1'b0;
  logic         inEop;
  logic         eopOk;
  logic         stuffError;
  logic         symError;
  int           rxCount = 0;
  int           cmpCount = 0;
  int           cycles = 0;

  pktCfg_t expCfg;
  string   curTest;

  usbHostTx i_dut (
    .clock,
    .reset_n,
    .apbReq,
    .apbRsp,
    .line
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
      $display("test failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic checkEq(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      $display("test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic apbWrite(input string name, input logic [4:0] addr, input logic [31:0] data,
                          input logic expErr);
    @(negedge clock);
    apbReq.psel = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite = 1'b1;
    apbReq.paddr = addr;
    apbReq.pwdata = data;
    @(negedge clock);
    apbReq.penable = 1'b1;
    #1;
    checkEq({name, " pready"}, 1, apbRsp.pready);
    checkEq({name, " pslverr"}, expErr, apbRsp.pslverr);
    @(negedge clock);
    apbReq = '0;
  endtask

  task automatic apbRead(input string name, input logic [4:0] addr, output logic [31:0] data);
    @(negedge clock);
    apbReq.psel = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite = 1'b0;
    apbReq.paddr = addr;
    apbReq.pwdata = '0;
    @(negedge clock);
    apbReq.penable = 1'b1;
    #1;
    data = apbRsp.prdata;
    checkEq({name, " read pready"}, 1, apbRsp.pready);
    checkEq({name, " read pslverr"}, 0, apbRsp.pslverr);
    @(negedge clock);
    apbReq = '0;
  endtask

  // Unstuffed bit list in line order, bit 0 goes out first
  function automatic void expectedBits(input pktCfg_t cfg, output logic [127:0] bits,
                                       output int len);
    logic [3:0]  pidBits;
    logic [10:0] token;
    logic [4:0]  crc5;
    logic [15:0] crc16;
    logic        b;
    bits = '0;
    len = 0;
    pidBits = cfg.pid;
    token = {cfg.endp, cfg.addr};
    crc5 = '1;
    crc16 = '1;
    for (int i = 0; i < SyncBits; i++) begin
      bits[len] = (i == SyncBits - 1);
      len++;
    end
    for (int i = 0; i < 4; i++) begin
      bits[len] = pidBits[i];
      len++;
    end
    for (int i = 0; i < 4; i++) begin
      bits[len] = ~pidBits[i];
      len++;
    end
    if (cfg.pid == PidOut || cfg.pid == PidIn) begin
      for (int i = 0; i < AddrWidth + EndpWidth; i++) begin
        b = token[i];
        bits[len] = b;
        len++;
        // x^5 + x^2 + 1
        crc5 = (crc5[4] ^ b) ? ({crc5[3:0], 1'b0} ^ 5'b00101) : {crc5[3:0], 1'b0};
      end
      crc5 = ~crc5;
      for (int i = 4; i >= 0; i--) begin
        bits[len] = crc5[i];
        len++;
      end
    end else if (cfg.pid == PidData0) begin
      for (int i = 0; i < PayloadWidth; i++) begin
        b = cfg.payload[i];
        bits[len] = b;
        len++;
        crc16 = (crc16[15] ^ b) ? ({crc16[14:0], 1'b0} ^ 16'h8005) : {crc16[14:0], 1'b0};
      end
      crc16 = ~crc16;
      for (int i = 15; i >= 0; i--) begin
        bits[len] = crc16[i];
        len++;
      end
    end
  endfunction

  // NRZI decode from J and destuff, one symbol per clock
  always @(negedge clock) begin
    if (reset_n && line.oe) begin
      if (!inPacket) begin
        inPacket = 1'b1;
        inEop = 1'b0;
        rxBits = '0;
        rxLen = 0;
        rawSyms = '0;
        rawLen = 0;
        onesRun = 0;
        se0Cnt = 0;
        jCnt = 0;
        prevLevel = 1'b1;
        stuffError = 1'b0;
        symError = 1'b0;
      end
      if (!line.dp && !line.dm) begin
        inEop = 1'b1;
        se0Cnt++;
      end else if (inEop) begin
        if (line.dp && !line.dm) begin
          jCnt++;
        end else begin
          symError = 1'b1;
        end
      end else begin
        if (line.dp == line.dm) begin
          symError = 1'b1;
        end
        rawSyms[rawLen] = line.dp;
        rawLen++;
        if (onesRun == StuffLimit) begin
          // Stuffed zero must toggle the line
          if (line.dp == prevLevel) begin
            stuffError = 1'b1;
          end
          onesRun = 0;
        end else if (line.dp == prevLevel) begin
          rxBits[rxLen] = 1'b1;
          rxLen++;
          onesRun++;
        end else begin
          rxBits[rxLen] = 1'b0;
          rxLen++;
          onesRun = 0;
        end
        prevLevel = line.dp;
      end
    end else if (inPacket) begin
      inPacket = 1'b0;
      eopOk = (se0Cnt == EopSe0Cycles) && (jCnt == 1);
      rxCount++;
    end
  end

  initial begin : compareProc
    logic [127:0] expBits;
    int           expLen;
    int           hold;
    int           maxHold;
    logic         level;
    forever begin
      wait (rxCount > cmpCount);
      expectedBits(expCfg, expBits, expLen);
      checkEq({curTest, " length"}, expLen, rxLen);
      checkEq({curTest, " bits"}, expBits, rxBits);
      checkEq({curTest, " stuffed zero"}, 0, stuffError);
      checkEq({curTest, " line states"}, 0, symError);
      checkEq({curTest, " eop"}, 1, eopOk);
      hold = 0;
      maxHold = 0;
      level = 1'b1;
      for (int i = 0; i < rawLen; i++) begin
        hold = (rawSyms[i] == level) ? hold + 1 : 0;
        level = rawSyms[i];
        if (hold > maxHold) begin
          maxHold = hold;
        end
      end
      checkEq({curTest, " run within limit"}, 1, maxHold <= StuffLimit);
      cmpCount++;
    end
  end

  task automatic sendPacket(input string name, input pktCfg_t cfg, input logic injectErrors);
    logic [31:0] rd;
    int          target;
    apbWrite({name, " pid"}, RegPid, 32'(cfg.pid), 1'b0);
    apbWrite({name, " addr"}, RegAddrEndp, {20'b0, cfg.endp, 1'b0, cfg.addr}, 1'b0);
    apbWrite({name, " data lo"}, RegDataLo, cfg.payload[31:0], 1'b0);
    apbWrite({name, " data hi"}, RegDataHi, cfg.payload[63:32], 1'b0);
    apbRead({name, " pid"}, RegPid, rd);
    checkEq({name, " pid readback"}, 32'(cfg.pid), rd);
    apbRead({name, " addr"}, RegAddrEndp, rd);
    checkEq({name, " addr readback"}, {20'b0, cfg.endp, 1'b0, cfg.addr}, rd);
    apbRead({name, " data lo"}, RegDataLo, rd);
    checkEq({name, " data lo readback"}, cfg.payload[31:0], rd);
    apbRead({name, " data hi"}, RegDataHi, rd);
    checkEq({name, " data hi readback"}, cfg.payload[63:32], rd);
    expCfg = cfg;
    curTest = name;
    target = cmpCount + 1;
    apbWrite({name, " start"}, RegCtrl, 32'h1, 1'b0);
    apbRead({name, " status"}, RegStatus, rd);
    checkEq({name, " busy during packet"}, 1, rd);
    if (injectErrors) begin
      apbWrite({name, " start while busy"}, RegCtrl, 32'h1, 1'b1);
      apbWrite({name, " invalid pid"}, RegPid, 32'hF, 1'b1);
      apbWrite({name, " unmapped offset"}, 5'h18, 32'h0, 1'b1);
      apbRead({name, " pid"}, RegPid, rd);
      checkEq({name, " pid after rejected write"}, 32'(cfg.pid), rd);
    end
    wait (cmpCount == target);
    apbRead({name, " status"}, RegStatus, rd);
    checkEq({name, " busy after packet"}, 0, rd);
  endtask

  initial begin
    pktCfg_t cfg;
    void'($urandom(Seed));
    reset_n = 1'b0;
    apbReq = '0;
    repeat (10) @(negedge clock);
    reset_n = 1'b1;

    cfg.pid = PidOut;
    cfg.addr = 7'($urandom);
    cfg.endp = 4'($urandom);
    cfg.payload = '0;
    sendPacket("out token", cfg, 1'b0);
    cfg.pid = PidIn;
    cfg.addr = 7'($urandom);
    cfg.endp = 4'($urandom);
    sendPacket("in token", cfg, 1'b0);

    cfg.pid = PidData0;
    cfg.payload = {$urandom, $urandom};
    sendPacket("data0 random", cfg, 1'b0);
    cfg.payload = '1;
    sendPacket("data0 all ones", cfg, 1'b0);

    cfg.pid = PidAck;
    sendPacket("ack handshake", cfg, 1'b0);
    cfg.pid = PidNak;
    sendPacket("nak handshake", cfg, 1'b0);

    // Rejected accesses while a DATA0 packet is on the line
    cfg.pid = PidData0;
    cfg.payload = {$urandom, $urandom};
    sendPacket("errors in flight", cfg, 1'b1);

    $display("test passed");
    $finish;
  end

endmodule

//--- src.f
src/usbPkg.sv
src/hostRegsPkg.sv
src/crcGenerator.sv
src/usbTxRegs.sv
src/packetSerializer.sv
src/bitStuffer.sv
src/lineDriver.sv
src/usbHostTx.sv
dv/usbHostTxTb.sv

//--- src/bitStuffer.sv
module bitStuffer import usbPkg::*; (
  input  logic   clock,
  input  logic   reset_n,
  input  txBit_t rawBit,
  output logic   ready,
  output txBit_t stuffedBit
);

  logic [2:0] onesCnt;
  logic       pendingLast;
  logic       stuffNow;
  logic       sixthOne;

  assign stuffNow = (onesCnt == 3'(StuffLimit));
  assign ready = !stuffNow;
  assign sixthOne = rawBit.value && (onesCnt == 3'(StuffLimit - 1));

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      onesCnt <= '0;
      pendingLast <= 1'b0;
      stuffedBit <= '0;
    end else if (stuffNow) begin
      // Stuffed zero takes over the end marker
      stuffedBit <= '{valid: 1'b1, value: 1'b0, last: pendingLast};
      onesCnt <= '0;
      pendingLast <= 1'b0;
    end else if (rawBit.valid) begin
      stuffedBit <= '{valid: 1'b1, value: rawBit.value, last: rawBit.last && !sixthOne};
      pendingLast <= rawBit.last && sixthOne;
      if (!rawBit.value || (rawBit.last && !sixthOne)) begin
        onesCnt <= '0;
      end else begin
        onesCnt <= onesCnt + 3'd1;
      end
    end else begin
      stuffedBit <= '0;
    end
  end

  assert property (@(posedge clock) disable iff (!reset_n) onesCnt <= 3'(StuffLimit));

endmodule

//--- src/crcGenerator.sv
module crcGenerator import usbPkg::*; #(
  parameter type crcT = crc5_t,
  parameter crcT Poly = Crc5Poly
) (
  input  logic clock,
  input  logic reset_n,
  input  logic clear,
  input  logic update,
  input  logic dataBit,
  input  logic shiftOut,
  output logic crcMsb
);

  localparam int Width = $bits(crcT);

  crcT  remainder;
  logic feedback;

  assign feedback = remainder[Width-1] ^ dataBit;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      remainder <= '1;
    end else if (clear) begin
      remainder <= '1;
    end else if (update) begin
      remainder <= {remainder[Width-2:0], 1'b0} ^ (Poly & {Width{feedback}});
    end else if (shiftOut) begin
      remainder <= {remainder[Width-2:0], 1'b1};
    end
  end

  // Remainder goes out inverted
  assign crcMsb = ~remainder[Width-1];

endmodule

//--- src/hostRegsPkg.sv
package hostRegsPkg;
  import usbPkg::*;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
  } apbReq_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apbRsp_t;

  localparam logic [4:0] RegCtrl = 5'h00;
  localparam logic [4:0] RegStatus = 5'h04;
  localparam logic [4:0] RegPid = 5'h08;
  localparam logic [4:0] RegAddrEndp = 5'h0C;
  localparam logic [4:0] RegDataLo = 5'h10;
  localparam logic [4:0] RegDataHi = 5'h14;

  typedef struct packed {
    pid_t                    pid;
    logic [AddrWidth-1:0]    addr;
    logic [EndpWidth-1:0]    endp;
    logic [PayloadWidth-1:0] payload;
  } pktCfg_t;

endpackage

//--- src/lineDriver.sv
module lineDriver import usbPkg::*; (
  input  logic     clock,
  input  logic     reset_n,
  input  txBit_t   stuffedBit,
  output usbLine_t line,
  output logic     eopDone
);

  typedef enum logic [1:0] {Data, Se0, EopJ, Release} state_t;

  state_t     state;
  logic       level;
  logic       nextLevel;
  logic [1:0] se0Cnt;

  // High level is J, a zero toggles it
  assign nextLevel = stuffedBit.value ? level : ~level;

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state <= Data;
      level <= 1'b1;
      se0Cnt <= '0;
      line <= '{dp: 1'b1, dm: 1'b0, oe: 1'b0};
      eopDone <= 1'b0;
    end else begin
      eopDone <= 1'b0;
      case (state)
        Data: begin
          if (stuffedBit.valid) begin
            level <= nextLevel;
            line <= '{dp: nextLevel, dm: ~nextLevel, oe: 1'b1};
            if (stuffedBit.last) begin
              state <= Se0;
              se0Cnt <= '0;
            end
          end
        end
        Se0: begin
          line <= '{dp: 1'b0, dm: 1'b0, oe: 1'b1};
          se0Cnt <= se0Cnt + 2'd1;
          if (se0Cnt == 2'(EopSe0Cycles - 1)) begin
            state <= EopJ;
          end
        end
        EopJ: begin
          line <= '{dp: 1'b1, dm: 1'b0, oe: 1'b1};
          level <= 1'b1;
          state <= Release;
        end
        default: begin
          line.oe <= 1'b0;
          eopDone <= 1'b1;
          state <= Data;
        end
      endcase
    end
  end

  // SE1 is illegal on a driven bus
  assert property (@(posedge clock) disable iff (!reset_n) line.oe |-> !(line.dp && line.dm));

endmodule

//--- src/packetSerializer.sv
module packetSerializer import usbPkg::*, hostRegsPkg::*; (
  input  logic    clock,
  input  logic    reset_n,
  input  logic    start,
  input  pktCfg_t cfg,
  output logic    busy,
  output txBit_t  rawBit,
  input  logic    ready,
  input  logic    eopDone
);

  typedef enum logic [3:0] {
    Idle, Sync, Pid, Addr, Endp, Crc5, Payload, Crc16, WaitEop
  } state_t;

  state_t                  state;
  state_t                  nextState;
  pktCfg_t                 pkt;
  logic [PayloadWidth-1:0] shiftReg;
  logic [PayloadWidth-1:0] nextField;
  logic [5:0]              bitCnt;
  logic [5:0]              nextCnt;
  logic                    advance;
  logic                    fieldDone;
  logic                    crc5Msb;
  logic                    crc16Msb;

  assign busy = (state != Idle);
  assign fieldDone = (bitCnt == '0);
  assign advance = rawBit.valid && ready;

  // Field that follows the current one
  always_comb begin
    nextState = WaitEop;
    nextField = '0;
    nextCnt = '0;
    case (state)
      Sync: begin
        nextState = Pid;
        nextField = PayloadWidth'({~pkt.pid, pkt.pid});
        nextCnt = 6'd7;
      end
      Pid: begin
        case (pkt.pid)
          PidOut, PidIn: begin
            nextState = Addr;
            nextField = PayloadWidth'(pkt.addr);
            nextCnt = 6'(AddrWidth - 1);
          end
          PidData0: begin
            nextState = Payload;
            nextField = pkt.payload;
            nextCnt = 6'(PayloadWidth - 1);
          end
          // Handshakes end after the PID
          default: nextState = WaitEop;
        endcase
      end
      Addr: begin
        nextState = Endp;
        nextField = PayloadWidth'(pkt.endp);
        nextCnt = 6'(EndpWidth - 1);
      end
      Endp: begin
        nextState = Crc5;
        nextCnt = 6'($bits(crc5_t) - 1);
      end
      Payload: begin
        nextState = Crc16;
        nextCnt = 6'($bits(crc16_t) - 1);
      end
      default: nextState = WaitEop;
    endcase
  end

  always_comb begin
    rawBit.valid = (state != Idle) && (state != WaitEop);
    case (state)
      Crc5:    rawBit.value = crc5Msb;
      Crc16:   rawBit.value = crc16Msb;
      default: rawBit.value = shiftReg[0];
    endcase
    rawBit.last = rawBit.valid && fieldDone && (nextState == WaitEop);
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state <= Idle;
      bitCnt <= '0;
    end else begin
      case (state)
        Idle: begin
          if (start) begin
            state <= Sync;
            bitCnt <= 6'(SyncBits - 1);
          end
        end
        WaitEop: begin
          if (eopDone) begin
            state <= Idle;
          end
        end
        default: begin
          if (advance) begin
            if (fieldDone) begin
              state <= nextState;
              bitCnt <= nextCnt;
            end else begin
              bitCnt <= bitCnt - 6'd1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      pkt <= cfg;
      // Seven zeros then a one
      shiftReg <= PayloadWidth'(1) << (SyncBits - 1);
    end else if (advance) begin
      shiftReg <= fieldDone ? nextField : (shiftReg >> 1);
    end
  end

  crcGenerator #(
    .crcT(crc5_t),
    .Poly(Crc5Poly)
  ) crc5Gen (
    .clock,
    .reset_n,
    .clear(start),
    .update(advance && ((state == Addr) || (state == Endp))),
    .dataBit(shiftReg[0]),
    .shiftOut(advance && (state == Crc5)),
    .crcMsb(crc5Msb)
  );

  crcGenerator #(
    .crcT(crc16_t),
    .Poly(Crc16Poly)
  ) crc16Gen (
    .clock,
    .reset_n,
    .clear(start),
    .update(advance && (state == Payload)),
    .dataBit(shiftReg[0]),
    .shiftOut(advance && (state == Crc16)),
    .crcMsb(crc16Msb)
  );

  // Bit on offer must hold through a stuffing stall
  assert property (@(posedge clock) disable iff (!reset_n)
    rawBit.valid && !ready |=> $stable(rawBit));

endmodule

//--- src/usbHostTx.sv
module usbHostTx import usbPkg::*, hostRegsPkg::*; (
  input  logic     clock,
  input  logic     reset_n,
  input  apbReq_t  apbReq,
  output apbRsp_t  apbRsp,
  output usbLine_t line
);

  logic    start;
  logic    busy;
  logic    ready;
  logic    eopDone;
  pktCfg_t cfg;
  txBit_t  rawBit;
  txBit_t  stuffedBit;

  usbTxRegs regs (
    .clock,
    .reset_n,
    .apbReq,
    .apbRsp,
    .busy,
    .start,
    .cfg
  );

  packetSerializer serializer (
    .clock,
    .reset_n,
    .start,
    .cfg,
    .busy,
    .rawBit,
    .ready,
    .eopDone
  );

  bitStuffer stuffer (
    .clock,
    .reset_n,
    .rawBit,
    .ready,
    .stuffedBit
  );

  lineDriver driver (
    .clock,
    .reset_n,
    .stuffedBit,
    .line,
    .eopDone
  );

endmodule

//--- src/usbPkg.sv
package usbPkg;

  // PID codes as sent on the wire, LSB first
  typedef enum logic [3:0] {
    PidOut   = 4'b0001,
    PidIn    = 4'b1001,
    PidData0 = 4'b0011,
    PidAck   = 4'b0010,
    PidNak   = 4'b1010
  } pid_t;

  localparam int AddrWidth = 7;
  localparam int EndpWidth = 4;
  localparam int PayloadWidth = 64;
  localparam int SyncBits = 8;

  typedef logic [4:0] crc5_t;
  typedef logic [15:0] crc16_t;

  // x^5 + x^2 + 1
  localparam crc5_t Crc5Poly = 5'b00101;
  // x^16 + x^15 + x^2 + 1
  localparam crc16_t Crc16Poly = 16'h8005;

  localparam int StuffLimit = 6;
  localparam int EopSe0Cycles = 2;

  typedef struct packed {
    logic valid;
    logic value;
    logic last;
  } txBit_t;

  typedef struct packed {
    logic dp;
    logic dm;
    logic oe;
  } usbLine_t;

endpackage

//--- src/usbTxRegs.sv
module usbTxRegs import usbPkg::*, hostRegsPkg::*; (
  input  logic    clock,
  input  logic    reset_n,
  input  apbReq_t apbReq,
  output apbRsp_t apbRsp,
  input  logic    busy,
  output logic    start,
  output pktCfg_t cfg
);

  logic        access;
  logic        write;
  logic        mapped;
  logic        pidOk;
  logic        startReq;
  logic        reject;
  logic [31:0] rdData;

  assign access = apbReq.psel && apbReq.penable;
  assign write = access && apbReq.pwrite;
  assign startReq = write && (apbReq.paddr == RegCtrl) && apbReq.pwdata[0];

  // Read mux, also flags unmapped offsets
  always_comb begin
    mapped = 1'b1;
    rdData = '0;
    case (apbReq.paddr)
      RegCtrl:     rdData = '0;
      RegStatus:   rdData = {31'b0, busy};
      RegPid:      rdData = {28'b0, cfg.pid};
      RegAddrEndp: rdData = {20'b0, cfg.endp, 1'b0, cfg.addr};
      RegDataLo:   rdData = cfg.payload[31:0];
      RegDataHi:   rdData = cfg.payload[63:32];
      default:     mapped = 1'b0;
    endcase
  end

  always_comb begin
    case (apbReq.pwdata[3:0])
      PidOut, PidIn, PidData0, PidAck, PidNak: pidOk = 1'b1;
      default: pidOk = 1'b0;
    endcase
  end

  // A start still in flight counts as busy
  assign reject = access && (!mapped ||
                             (write && (apbReq.paddr == RegPid) && !pidOk) ||
                             (startReq && (busy || start)));

  assign apbRsp.pready = 1'b1;
  assign apbRsp.pslverr = reject;
  assign apbRsp.prdata = rdData;

  always_ff @(posedge clock) begin
    if (write && !reject) begin
      case (apbReq.paddr)
        RegPid:      cfg.pid <= pid_t'(apbReq.pwdata[3:0]);
        RegAddrEndp: begin
          cfg.addr <= apbReq.pwdata[6:0];
          cfg.endp <= apbReq.pwdata[11:8];
        end
        RegDataLo:   cfg.payload[31:0] <= apbReq.pwdata;
        RegDataHi:   cfg.payload[63:32] <= apbReq.pwdata;
        default:     ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      start <= 1'b0;
    end else begin
      start <= startReq && !reject;
    end
  end

  // Serializer must be idle whenever a packet is launched
  assert property (@(posedge clock) disable iff (!reset_n) start |-> !busy);

endmodule
